// File: include/platform_config.svh
// platform build configuration
`ifndef PLATFORM_CONFIG_SVH
`define PLATFORM_CONFIG_SVH

// sys_clk cycles per serial bit, kept short for simulation
`define CLKS_PER_BIT 8

// log2 of memory depth in 32-bit words
`define MEM_SIZE_POT 6

// bus widths
`define ADDR_W 8
`define DATA_W 32

// bytes per command frame, opcode included
`define WR_FRAME_BYTES 6
`define RD_FRAME_BYTES 2

`endif

// File: src/wb_pkg.sv
// wishbone bus bundles
`include "platform_config.svh"

package wb_pkg;

    // master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        // word address
        logic [`ADDR_W-1:0]  addr;
        logic [3:0]          sel;
        logic [`DATA_W-1:0]  wdata;
    } wb_req_t;

    // slave to master, exactly one of ack or err per transfer
    typedef struct packed {
        logic                ack;
        logic                err;
        logic [`DATA_W-1:0]  rdata;
    } wb_rsp_t;

endpackage: wb_pkg

// File: src/loader_pkg.sv
// serial loader protocol types

package loader_pkg;

    // command byte, first byte of every frame
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52
    } opcode_e;

    // single byte replies
    typedef enum logic [7:0] {
        // write done
        RPL_OK  = 8'h4B,
        RPL_ERR = 8'hEE
    } reply_e;

    // status leds, error flag on the top bit
    typedef struct packed {
        logic       err;
        logic [6:0] count;
    } led_t;

endpackage: loader_pkg

// File: src/uart_rx.sv
// serial byte receiver
`timescale 1ns/100ps
`include "platform_config.svh"

module uart_rx
(
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic       rxd_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);

localparam int CLKS  = `CLKS_PER_BIT;
localparam int CNT_W = $clog2(CLKS);

typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

rx_state_e        state_q;
logic [1:0]       sync_q;
logic             rxd_s;
logic [CNT_W-1:0] clk_cnt_q;
logic [2:0]       bit_cnt_q;
logic             period_end;

// two-flop synchronizer, line idles high
always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
        sync_q <= 2'b11;
    else
        sync_q <= {sync_q[0], rxd_i};
end

assign rxd_s      = sync_q[1];
assign period_end = (clk_cnt_q == CNT_W'(CLKS - 1));

always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
    begin
        state_q    <= RX_IDLE;
        clk_cnt_q  <= '0;
        bit_cnt_q  <= '0;
        rx_valid_o <= 1'b0;
    end
    else
    begin
        rx_valid_o <= 1'b0;
        clk_cnt_q  <= period_end ? '0 : clk_cnt_q + 1'b1;
        case (state_q)
            RX_IDLE:
            begin
                clk_cnt_q <= '0;
                if (!rxd_s)
                    state_q <= RX_START;
            end
            RX_START:
            begin
                // middle of start bit, realign counter to bit centres
                if (clk_cnt_q == CNT_W'(CLKS / 2 - 1))
                begin
                    clk_cnt_q <= '0;
                    bit_cnt_q <= '0;
                    state_q   <= rxd_s ? RX_IDLE : RX_DATA;
                end
            end
            RX_DATA:
            begin
                if (period_end)
                begin
                    bit_cnt_q <= bit_cnt_q + 3'd1;
                    if (bit_cnt_q == 3'd7)
                        state_q <= RX_STOP;
                end
            end
            RX_STOP:
            begin
                // low stop bit means framing error, byte is lost
                if (period_end)
                begin
                    rx_valid_o <= rxd_s;
                    state_q    <= RX_IDLE;
                end
            end
            default: state_q <= RX_IDLE;
        endcase
    end
end

// lsb arrives first
always_ff @(posedge sys_clk)
begin
    if (state_q == RX_DATA && period_end)
        rx_data_o <= {rxd_s, rx_data_o[7:1]};
end

assert property (@(posedge sys_clk) disable iff (!rst_n_i)
    rx_valid_o |=> !rx_valid_o);

endmodule: uart_rx

// File: src/uart_tx.sv
// serial byte transmitter
`timescale 1ns/100ps
`include "platform_config.svh"

module uart_tx
(
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_valid_i,
    output logic       tx_ready_o,
    output logic       txd_o
);

localparam int CLKS  = `CLKS_PER_BIT;
localparam int CNT_W = $clog2(CLKS);

logic             busy_q;
logic [9:0]       shift_q;
logic [CNT_W-1:0] clk_cnt_q;
logic [3:0]       bit_cnt_q;
logic             period_end;

assign tx_ready_o = !busy_q;
assign period_end = (clk_cnt_q == CNT_W'(CLKS - 1));
// line idles on the ones shifted in behind the stop bit
assign txd_o      = shift_q[0];

always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
    begin
        busy_q    <= 1'b0;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
    end
    else if (!busy_q)
    begin
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
        if (tx_valid_i)
            busy_q <= 1'b1;
    end
    else
    begin
        clk_cnt_q <= period_end ? '0 : clk_cnt_q + 1'b1;
        if (period_end)
        begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            // last cycle of the stop bit
            if (bit_cnt_q == 4'd9)
                busy_q <= 1'b0;
        end
    end
end

// stop, data lsb first, start
always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
        shift_q <= '1;
    else if (tx_valid_i && tx_ready_o)
        shift_q <= {1'b1, tx_data_i, 1'b0};
    else if (busy_q && period_end)
        shift_q <= {1'b1, shift_q[9:1]};
end

assert property (@(posedge sys_clk) disable iff (!rst_n_i)
    tx_ready_o |-> txd_o);

endmodule: uart_tx

// File: src/sp_mem_wb.sv
// single-port word memory
`timescale 1ns/100ps
`include "platform_config.svh"

module sp_mem_wb
(
    input  logic            sys_clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);

localparam int DEPTH = 1 << `MEM_SIZE_POT;

logic [`DATA_W-1:0]       mem [DEPTH];
logic [`MEM_SIZE_POT-1:0] idx;
logic                     in_range;
logic                     req_new;
logic                     ack_q;
logic                     err_q;
logic [`DATA_W-1:0]       rdata_q;

assign idx      = wb_req_i.addr[`MEM_SIZE_POT-1:0];
assign in_range = (wb_req_i.addr < `ADDR_W'(DEPTH));
// one response per strobe, the master holds stb through the ack cycle
assign req_new  = wb_req_i.cyc && wb_req_i.stb && !(ack_q || err_q);

always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
    begin
        ack_q <= 1'b0;
        err_q <= 1'b0;
    end
    else
    begin
        ack_q <= req_new && in_range;
        err_q <= req_new && !in_range;
    end
end

always_ff @(posedge sys_clk)
begin
    if (req_new && in_range)
    begin
        if (wb_req_i.we)
        begin
            for (int i = 0; i < `DATA_W / 8; i++)
            begin
                if (wb_req_i.sel[i])
                    mem[idx][8*i +: 8] <= wb_req_i.wdata[8*i +: 8];
            end
        end
        rdata_q <= mem[idx];
    end
end

assign wb_rsp_o.ack   = ack_q;
assign wb_rsp_o.err   = err_q;
assign wb_rsp_o.rdata = rdata_q;

assert property (@(posedge sys_clk) disable iff (!rst_n_i)
    !(wb_rsp_o.ack && wb_rsp_o.err));

// responses only follow a strobe
assert property (@(posedge sys_clk) disable iff (!rst_n_i)
    (wb_rsp_o.ack || wb_rsp_o.err) |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule: sp_mem_wb

// File: src/wb_loader.sv
// serial frame loader and bus master
`timescale 1ns/100ps
`include "platform_config.svh"

module wb_loader
(
    input  logic               sys_clk,
    input  logic               rst_n_i,
    input  logic [7:0]         rx_data_i,
    input  logic               rx_valid_i,
    output logic [7:0]         tx_data_o,
    output logic               tx_valid_o,
    input  logic               tx_ready_i,
    output wb_pkg::wb_req_t    wb_req_o,
    input  wb_pkg::wb_rsp_t    wb_rsp_i,
    output loader_pkg::led_t   led_o
);

typedef enum logic [1:0] {S_OPCODE, S_COLLECT, S_BUS, S_REPLY} ld_state_e;

ld_state_e            state_q;
loader_pkg::opcode_e  op_q;
logic [`ADDR_W-1:0]   addr_q;
logic [`DATA_W-1:0]   wdata_q;
logic [`DATA_W-1:0]   reply_q;
logic [2:0]           byte_cnt_q;
logic [2:0]           reply_cnt_q;
logic                 op_known;
logic                 frame_last;
logic                 bus_done;
logic                 tx_fire;
logic                 err_set;

assign op_known = (rx_data_i == loader_pkg::OP_WRITE) || (rx_data_i == loader_pkg::OP_READ);

// byte count includes the opcode
assign frame_last = (op_q == loader_pkg::OP_READ) ?
                    (byte_cnt_q == 3'(`RD_FRAME_BYTES - 1)) :
                    (byte_cnt_q == 3'(`WR_FRAME_BYTES - 1));

assign bus_done = (state_q == S_BUS) && (wb_rsp_i.ack || wb_rsp_i.err);
assign tx_fire  = tx_valid_o && tx_ready_i;

// unknown opcode, byte dropped while busy, or bus error
assign err_set = (rx_valid_i && state_q == S_OPCODE && !op_known) ||
                 (rx_valid_i && (state_q == S_BUS || state_q == S_REPLY)) ||
                 (state_q == S_BUS && wb_rsp_i.err);

always_ff @(posedge sys_clk)
begin
    if (!rst_n_i)
    begin
        state_q     <= S_OPCODE;
        byte_cnt_q  <= '0;
        reply_cnt_q <= '0;
        led_o       <= '0;
    end
    else
    begin
        if (err_set)
            led_o.err <= 1'b1;
        // errored frames still count, wraps at 128
        if (bus_done)
            led_o.count <= led_o.count + 7'd1;

        case (state_q)
            S_OPCODE:
            begin
                if (rx_valid_i && op_known)
                begin
                    byte_cnt_q <= 3'd1;
                    state_q    <= S_COLLECT;
                end
            end
            S_COLLECT:
            begin
                if (rx_valid_i)
                begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                    if (frame_last)
                        state_q <= S_BUS;
                end
            end
            S_BUS:
            begin
                if (bus_done)
                begin
                    // a good read returns the whole word
                    reply_cnt_q <= (wb_rsp_i.ack && op_q == loader_pkg::OP_READ) ?
                                   3'(`DATA_W / 8) : 3'd1;
                    state_q     <= S_REPLY;
                end
            end
            S_REPLY:
            begin
                if (tx_fire)
                begin
                    reply_cnt_q <= reply_cnt_q - 3'd1;
                    if (reply_cnt_q == 3'd1)
                        state_q <= S_OPCODE;
                end
            end
            default: state_q <= S_OPCODE;
        endcase
    end
end

// frame fields and reply word
always_ff @(posedge sys_clk)
begin
    if (state_q == S_OPCODE && rx_valid_i && op_known)
        op_q <= loader_pkg::opcode_e'(rx_data_i);

    if (state_q == S_COLLECT && rx_valid_i)
    begin
        if (byte_cnt_q == 3'd1)
            addr_q <= rx_data_i;
        else
            wdata_q <= {rx_data_i, wdata_q[`DATA_W-1:8]};
    end

    if (bus_done)
    begin
        if (wb_rsp_i.err)
            reply_q <= `DATA_W'(loader_pkg::RPL_ERR);
        else if (op_q == loader_pkg::OP_READ)
            reply_q <= wb_rsp_i.rdata;
        else
            reply_q <= `DATA_W'(loader_pkg::RPL_OK);
    end
    else if (state_q == S_REPLY && tx_fire)
        reply_q <= reply_q >> 8;
end

// request held for the whole bus state, drops the cycle after ack or err
always_comb
begin
    wb_req_o.cyc   = (state_q == S_BUS);
    wb_req_o.stb   = (state_q == S_BUS);
    wb_req_o.we    = (op_q == loader_pkg::OP_WRITE);
    wb_req_o.addr  = addr_q;
    wb_req_o.sel   = '1;
    wb_req_o.wdata = wdata_q;
end

assign tx_valid_o = (state_q == S_REPLY);
assign tx_data_o  = reply_q[7:0];

assert property (@(posedge sys_clk) disable iff (!rst_n_i)
    (wb_req_o.stb && !(wb_rsp_i.ack || wb_rsp_i.err)) |=> $stable(wb_req_o));

endmodule: wb_loader

// File: src/platform_top.sv
// serial memory loader platform
`timescale 1ns/100ps

module platform_top
(
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic       uart_rx_i,
    output logic       uart_tx_o,
    output logic [7:0] led_o
);

logic             rst_n;
logic [2:0]       rst_sync_q;
logic [7:0]       rx_data;
logic             rx_valid;
logic [7:0]       tx_data;
logic             tx_valid;
logic             tx_ready;
wb_pkg::wb_req_t  wb_req;
wb_pkg::wb_rsp_t  wb_rsp;
loader_pkg::led_t led_status;

// three flops, internal reset follows rst_n_i by 3 cycles
always_ff @(posedge sys_clk)
begin
    rst_sync_q <= {rst_sync_q[1:0], rst_n_i};
end

assign rst_n = rst_sync_q[2];

uart_rx i_uart_rx
(
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n),
    .rxd_i      (uart_rx_i),
    .rx_data_o  (rx_data),
    .rx_valid_o (rx_valid)
);

uart_tx i_uart_tx
(
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n),
    .tx_data_i  (tx_data),
    .tx_valid_i (tx_valid),
    .tx_ready_o (tx_ready),
    .txd_o      (uart_tx_o)
);

// host side bus master
wb_loader i_loader
(
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_data_o  (tx_data),
    .tx_valid_o (tx_valid),
    .tx_ready_i (tx_ready),
    .wb_req_o   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .led_o      (led_status)
);

sp_mem_wb i_mem
(
    .sys_clk  (sys_clk),
    .rst_n_i  (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
);

assign led_o = led_status;

endmodule: platform_top

// File: testbench/tb_platform_top.sv
// serial loader platform testbench
`timescale 1ns/100ps
`include "platform_config.svh"

module tb_platform_top;

localparam int CLKS    = `CLKS_PER_BIT;
localparam int DEPTH   = 1 << `MEM_SIZE_POT;
localparam int N_WORDS = 8;
localparam int N_B2B   = 4;
// host bytes plus reply bytes of the whole sequence
localparam int FRAME_BYTES = N_WORDS * (6 + 1) + N_WORDS * (2 + 4) + (6 + 1) + (2 + 1)
                             + (2 + 4) + 1 + (2 + 4) + N_B2B * (2 + 4);
localparam int MAX_CYCLES  = FRAME_BYTES * 10 * CLKS * 3 / 2;

logic             sys_clk;
logic             rst_n_i;
logic             uart_rx_i;
logic             uart_tx_o;
logic [7:0]       led_o;

logic [7:0]       exp_q [$];
logic [7:0]       reply_q [$];
logic [31:0]      ref_mem [DEPTH];
loader_pkg::led_t exp_led     = '0;
int               exp_total   = 0;
logic             rx_strobe   = 1'b0;
logic             exp_present = 1'b0;
logic [7:0]       got_byte    = 8'h00;
logic [7:0]       exp_byte    = 8'h00;
logic             led_check   = 1'b0;
logic             idle_phase  = 1'b0;
int               cycles      = 0;
int               seed;

int reply_errs = 0;
int stray_errs = 0;
int led_errs   = 0;
int idle_errs  = 0;
int stop_errs  = 0;
int count_errs = 0;

platform_top i_dut
(
    .sys_clk   (sys_clk),
    .rst_n_i   (rst_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .led_o     (led_o)
);

initial
begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
end

function automatic int total_errors();
    return reply_errs + stray_errs + led_errs + idle_errs + stop_errs + count_errs;
endfunction

task automatic print_counts();
    $display("errors: reply %0d, stray %0d, led %0d, idle %0d, stop bit %0d, count %0d",
             reply_errs, stray_errs, led_errs, idle_errs, stop_errs, count_errs);
endtask

// 16 cycles low, internal reset trails by three flops
task automatic apply_reset();
    rst_n_i <= 1'b0;
    repeat (16) @(posedge sys_clk);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge sys_clk);
    exp_led = '0;
endtask

// start, 8 data bits lsb first, stop
task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
        uart_rx_i <= frame[i];
        repeat (CLKS) @(posedge sys_clk);
    end
endtask

// called one cycle into the start bit
task automatic receive_byte(output logic [7:0] b, output logic stop_ok);
    repeat (CLKS / 2) @(posedge sys_clk);
    for (int i = 0; i < 8; i++)
    begin
        repeat (CLKS) @(posedge sys_clk);
        b[i] = uart_tx_o;
    end
    repeat (CLKS) @(posedge sys_clk);
    stop_ok = uart_tx_o;
endtask

task automatic expect_byte(input logic [7:0] b);
    exp_q.push_back(b);
    exp_total = exp_total + 1;
endtask

// drain replies, then sample the leds
task automatic finish_frame();
    while (exp_q.size() != 0)
        @(posedge sys_clk);
    repeat (2) @(posedge sys_clk);
    led_check <= 1'b1;
    @(posedge sys_clk);
    led_check <= 1'b0;
endtask

task automatic send_write(input logic [7:0] addr, input logic [31:0] data);
    if (int'(addr) < DEPTH)
    begin
        ref_mem[addr[`MEM_SIZE_POT-1:0]] = data;
        expect_byte(loader_pkg::RPL_OK);
    end
    else
    begin
        expect_byte(loader_pkg::RPL_ERR);
        exp_led.err = 1'b1;
    end
    exp_led.count = exp_led.count + 7'd1;
    send_byte(loader_pkg::OP_WRITE);
    send_byte(addr);
    for (int i = 0; i < 4; i++)
        send_byte(data[8*i +: 8]);
    finish_frame();
endtask

task automatic send_read(input logic [7:0] addr);
    logic [31:0] word;
    if (int'(addr) < DEPTH)
    begin
        word = ref_mem[addr[`MEM_SIZE_POT-1:0]];
        for (int i = 0; i < 4; i++)
            expect_byte(word[8*i +: 8]);
    end
    else
    begin
        expect_byte(loader_pkg::RPL_ERR);
        exp_led.err = 1'b1;
    end
    exp_led.count = exp_led.count + 7'd1;
    send_byte(loader_pkg::OP_READ);
    send_byte(addr);
    finish_frame();
endtask

// host side of the serial link, reply bytes in arrival order
initial
begin : tx_monitor
    logic [7:0] b;
    logic       stop_ok;
    forever
    begin
        @(posedge sys_clk);
        if (rst_n_i && !uart_tx_o)
        begin
            receive_byte(b, stop_ok);
            if (!stop_ok)
            begin
                stop_errs = stop_errs + 1;
                $display("stop bit on uart_tx_o was low at %0t ns", $time);
            end
            reply_q.push_back(b);
            got_byte    <= b;
            exp_present <= (exp_q.size() != 0);
            if (exp_q.size() != 0)
                exp_byte <= exp_q.pop_front();
            rx_strobe <= 1'b1;
            @(posedge sys_clk);
            rx_strobe <= 1'b0;
        end
    end
end

initial
begin : main_seq
    logic [31:0] rnd;
    logic [7:0]  wr_addr [N_WORDS];
    rst_n_i   = 1'b0;
    uart_rx_i = 1'b1;
    seed      = 84;
    apply_reset();
    idle_phase <= 1'b1;
    repeat (40) @(posedge sys_clk);
    idle_phase <= 1'b0;

    for (int i = 0; i < N_WORDS; i++)
    begin
        rnd        = $random(seed);
        wr_addr[i] = 8'(rnd[`MEM_SIZE_POT-1:0]);
        rnd        = $random(seed);
        send_write(wr_addr[i], rnd);
    end
    for (int i = 0; i < N_WORDS; i++)
        send_read(wr_addr[i]);

    // aliases onto wr_addr[0] if the range check were missing
    send_write(8'(DEPTH + int'(wr_addr[0])), 32'hDEAD_BEEF);
    send_read(8'hC8);
    send_read(wr_addr[0]);

    // clears the sticky flag, memory keeps its contents
    apply_reset();
    send_byte(8'h3F);
    exp_led.err = 1'b1;
    repeat (10 * CLKS) @(posedge sys_clk);
    finish_frame();
    send_read(wr_addr[1]);

    for (int i = 0; i < N_B2B; i++)
        send_read(wr_addr[N_WORDS - 1 - i]);

    repeat (4) @(posedge sys_clk);
    if (reply_q.size() != exp_total)
    begin
        count_errs = count_errs + 1;
        $display("received %0d reply bytes but %0d were expected", reply_q.size(), exp_total);
    end
    print_counts();
    if (total_errors() == 0)
        $display("SIMULATION PASSED");
    else
        $display("SIMULATION FAILED");
    $finish;
end

initial
begin : watchdog
    while (cycles < MAX_CYCLES)
    begin
        @(posedge sys_clk);
        cycles = cycles + 1;
    end
    $display("timeout after %0d cycles, a frame or reply never completed", cycles);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
end

reply_value_chk: assert property (@(posedge sys_clk) (rx_strobe && exp_present) |->
                                  got_byte == exp_byte)
    else
    begin
        reply_errs = reply_errs + 1;
        $display("** Error: %0t ns: uart_tx_o reply byte expected %02h, got %02h",
                 $time, $sampled(exp_byte), $sampled(got_byte));
    end

// a reply with nothing outstanding
reply_stray_chk: assert property (@(posedge sys_clk) rx_strobe |-> exp_present)
    else
    begin
        stray_errs = stray_errs + 1;
        $display("reply byte %02h arrived at %0t ns with no reply pending",
                 $sampled(got_byte), $time);
    end

led_chk: assert property (@(posedge sys_clk) led_check |-> led_o == exp_led)
    else
    begin
        led_errs = led_errs + 1;
        $display("** Error: %0t ns: led_o expected %02h, got %02h",
                 $time, $sampled(exp_led), $sampled(led_o));
    end

idle_chk: assert property (@(posedge sys_clk) idle_phase |->
                           (uart_tx_o == 1'b1 && led_o == 8'h00))
    else
    begin
        idle_errs = idle_errs + 1;
        $display("** Error: %0t ns: uart_tx_o expected 1, got %b; led_o expected 00, got %02h",
                 $time, $sampled(uart_tx_o), $sampled(led_o));
    end

endmodule: tb_platform_top

// File: platform_top.f
+incdir+include
src/wb_pkg.sv
src/loader_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/sp_mem_wb.sv
src/wb_loader.sv
src/platform_top.sv
testbench/tb_platform_top.sv

// File: Makefile
# Verilator build and run for the serial loader platform

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_platform_top
FILELIST := platform_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, grep returns non-zero when the pass line is missing
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
